// ==== ext_bus_demux.sv ====
/* Address decode and request routing to memory, power block
   or error responder, with in-order response return */
`timescale 1ns/100ps
`default_nettype none

`include "ext_consts.svh"

module ext_bus_demux (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  ext_pkg::bus_req_t host_req_i,
  output ext_pkg::bus_rsp_t host_rsp_o,
  output ext_pkg::bus_req_t mem_req_o,
  input  ext_pkg::bus_rsp_t mem_rsp_i,
  output ext_pkg::bus_req_t pwr_req_o,
  input  ext_pkg::bus_rsp_t pwr_rsp_i
);

  localparam int CNT_W = $clog2(`MAX_OUTSTANDING + 1);

  ext_pkg::target_t tgt;
  ext_pkg::target_t cur_tgt_q;
  logic [CNT_W-1:0] cnt_q;
  logic             stall;
  logic             accept;
  logic             err_rvalid_q;

  // Regions are aligned powers of two
  always_comb begin
    if ((host_req_i.addr & ~ext_pkg::addr_t'(`MEM_SIZE - 1)) == `MEM_BASE) begin
      tgt = ext_pkg::MEM;
    end else if ((host_req_i.addr & ~ext_pkg::addr_t'(`PWR_SIZE - 1)) == `PWR_BASE) begin
      tgt = ext_pkg::PWR;
    end else begin
      tgt = ext_pkg::ERR;
    end
  end

  // Hold off a new target until the old one has answered everything
  assign stall = (cnt_q == CNT_W'(`MAX_OUTSTANDING)) ||
                 ((cnt_q != '0) && (tgt != cur_tgt_q));

  always_comb begin
    mem_req_o     = host_req_i;
    pwr_req_o     = host_req_i;
    mem_req_o.req = host_req_i.req && !stall && (tgt == ext_pkg::MEM);
    pwr_req_o.req = host_req_i.req && !stall && (tgt == ext_pkg::PWR);
  end

  always_comb begin
    host_rsp_o.gnt = 1'b0;
    if (host_req_i.req && !stall) begin
      case (tgt)
        ext_pkg::MEM: host_rsp_o.gnt = mem_rsp_i.gnt;
        ext_pkg::PWR: host_rsp_o.gnt = pwr_rsp_i.gnt;
        default:      host_rsp_o.gnt = 1'b1;
      endcase
    end
    host_rsp_o.rvalid = mem_rsp_i.rvalid | pwr_rsp_i.rvalid | err_rvalid_q;
    // Every pending response belongs to cur_tgt_q
    case (cur_tgt_q)
      ext_pkg::MEM: host_rsp_o.rdata = mem_rsp_i.rdata;
      ext_pkg::PWR: host_rsp_o.rdata = pwr_rsp_i.rdata;
      default:      host_rsp_o.rdata = `ERR_RDATA;
    endcase
  end

  assign accept = host_req_i.req && host_rsp_o.gnt;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q        <= '0;
      cur_tgt_q    <= ext_pkg::MEM;
      err_rvalid_q <= 1'b0;
    end else begin
      err_rvalid_q <= accept && (tgt == ext_pkg::ERR);
      if (accept) begin
        cur_tgt_q <= tgt;
      end
      case ({accept, host_rsp_o.rvalid})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Targets only answer what this demux handed them
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (mem_rsp_i.rvalid || pwr_rsp_i.rvalid) |-> (cnt_q != '0));

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cnt_q <= CNT_W'(`MAX_OUTSTANDING));

endmodule

`default_nettype wire

// ==== ext_consts.svh ====
/* Bus widths, memory map, queue depths and latencies
   of the external bus subsystem */
`ifndef EXT_CONSTS_SVH
`define EXT_CONSTS_SVH

`define EXT_ADDR_W          32
`define EXT_DATA_W          32
`define EXT_BE_W            4

// Slow memory, 32 KiB at the bottom of the map
`define MEM_NUM_WORDS       8192
`define MEM_IDX_W           13
`define MEM_BASE            32'h0000_0000
`define MEM_SIZE            32'h0000_8000

// Power switch registers
`define PWR_BASE            32'h0001_0000
`define PWR_SIZE            32'h0000_0100
`define PWR_OFS_W           8
`define PWR_SWITCH_OFS      8'h00
`define PWR_ACK_OFS         8'h04
`define EXT_DOMAINS         4
`define SWITCH_ACK_LATENCY  15

`define MEM_LATENCY         3
`define FIFO_DEPTH          2
`define MAX_OUTSTANDING     4
`define ERR_RDATA           32'hBADC_AB1E

`endif

// ==== ext_pkg.sv ====
/* Bus request and response structs, width typedefs
   and FSM encodings shared by the subsystem */
`default_nettype none

`include "ext_consts.svh"

package ext_pkg;

  typedef logic [`EXT_ADDR_W-1:0]  addr_t;
  typedef logic [`EXT_DATA_W-1:0]  data_t;
  typedef logic [`EXT_BE_W-1:0]    be_t;
  typedef logic [`MEM_IDX_W-1:0]   mem_idx_t;
  typedef logic [`EXT_DOMAINS-1:0] domain_mask_t;

  // Where the demux sends a request
  typedef enum logic [1:0] {
    MEM = 2'd0,
    PWR = 2'd1,
    ERR = 2'd2
  } target_t;

  typedef struct packed {
    logic  req;
    logic  we;
    be_t   be;
    addr_t addr;
    data_t wdata;
  } bus_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    data_t rdata;
  } bus_rsp_t;

  typedef enum logic {
    IDLE = 1'b0,
    BUSY = 1'b1
  } mem_state_t;

endpackage

`default_nettype wire

// ==== ext_subsys_top.sv ====
/* External subsystem: bus demux, request FIFO,
   slow memory and power switch block */
`timescale 1ns/100ps
`default_nettype none

module ext_subsys_top (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  ext_pkg::bus_req_t     bus_req_i,
  output ext_pkg::bus_rsp_t     bus_rsp_o,
  output ext_pkg::domain_mask_t pwr_switch_n_o,
  output ext_pkg::domain_mask_t pwr_ack_n_o
);

  ext_pkg::bus_req_t mem_req;
  ext_pkg::bus_rsp_t mem_rsp;
  ext_pkg::bus_req_t fifo_out_req;
  ext_pkg::bus_rsp_t fifo_out_rsp;
  ext_pkg::bus_req_t pwr_req;
  ext_pkg::bus_rsp_t pwr_rsp;

  ext_bus_demux ext_bus_demux_i (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .host_req_i (bus_req_i),
    .host_rsp_o (bus_rsp_o),
    .mem_req_o  (mem_req),
    .mem_rsp_i  (mem_rsp),
    .pwr_req_o  (pwr_req),
    .pwr_rsp_i  (pwr_rsp)
  );

  // Extra latency on the way to the slow memory
  obi_fifo obi_fifo_i (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .producer_req_i (mem_req),
    .producer_rsp_o (mem_rsp),
    .consumer_req_o (fifo_out_req),
    .consumer_rsp_i (fifo_out_rsp)
  );

  slow_memory slow_ram_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (fifo_out_req),
    .rsp_o    (fifo_out_rsp)
  );

  power_switch_ctrl power_switch_ctrl_i (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .req_i          (pwr_req),
    .rsp_o          (pwr_rsp),
    .pwr_switch_n_o (pwr_switch_n_o),
    .pwr_ack_n_o    (pwr_ack_n_o)
  );

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
ext_pkg.sv
ext_bus_demux.sv
obi_fifo.sv
slow_memory.sv
power_switch_ctrl.sv
ext_subsys_top.sv
tb_ext_subsys.sv

// ==== obi_fifo.sv ====
/* Request queue in front of the slow memory,
   responses pass straight back */
`timescale 1ns/100ps
`default_nettype none

`include "ext_consts.svh"

module obi_fifo (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  ext_pkg::bus_req_t producer_req_i,
  output ext_pkg::bus_rsp_t producer_rsp_o,
  output ext_pkg::bus_req_t consumer_req_o,
  input  ext_pkg::bus_rsp_t consumer_rsp_i
);

  localparam int PTR_W = ($clog2(`FIFO_DEPTH) > 0) ? $clog2(`FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

  ext_pkg::bus_req_t entries_q [`FIFO_DEPTH];
  logic [PTR_W-1:0]  head_q;
  logic [PTR_W-1:0]  tail_q;
  logic [CNT_W-1:0]  count_q;
  logic              full;
  logic              empty;
  logic              push;
  logic              pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(`FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full  = (count_q == CNT_W'(`FIFO_DEPTH));
  assign empty = (count_q == '0);
  assign push  = producer_req_i.req && !full;
  assign pop   = consumer_req_o.req && consumer_rsp_i.gnt;

  always_comb begin
    producer_rsp_o.gnt    = push;
    producer_rsp_o.rvalid = consumer_rsp_i.rvalid;
    producer_rsp_o.rdata  = consumer_rsp_i.rdata;
    consumer_req_o        = entries_q[head_q];
    consumer_req_o.req    = !empty;
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      entries_q[tail_q] <= producer_req_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) tail_q <= next_ptr(tail_q);
      if (pop) head_q <= next_ptr(head_q);
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Never more entries than slots
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    count_q <= CNT_W'(`FIFO_DEPTH));

  // Downstream must not take an entry that isn't there
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    consumer_rsp_i.gnt |-> !empty);

endmodule

`default_nettype wire

// ==== power_switch_ctrl.sv ====
/* Power switch register for the external domains, switch cell
   acknowledge delay model and acknowledge status readback */
`timescale 1ns/100ps
`default_nettype none

`include "ext_consts.svh"

module power_switch_ctrl (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  ext_pkg::bus_req_t     req_i,
  output ext_pkg::bus_rsp_t     rsp_o,
  output ext_pkg::domain_mask_t pwr_switch_n_o,
  output ext_pkg::domain_mask_t pwr_ack_n_o
);

  logic [`PWR_OFS_W-1:0] ofs;
  logic                  gnt;
  ext_pkg::domain_mask_t switch_q;
  ext_pkg::domain_mask_t ack_pipe_q [`SWITCH_ACK_LATENCY];
  logic                  rvalid_q;
  ext_pkg::data_t        rdata_q;

  assign ofs = req_i.addr[`PWR_OFS_W-1:0];
  assign gnt = req_i.req;

  always_comb begin
    rsp_o.gnt    = gnt;
    rsp_o.rvalid = rvalid_q;
    rsp_o.rdata  = rdata_q;
  end

  // Active low, 0 means domain powered
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      switch_q <= '0;
    end else if (gnt && req_i.we && req_i.be[0] && (ofs == `PWR_SWITCH_OFS)) begin
      switch_q <= req_i.wdata[`EXT_DOMAINS-1:0];
    end
  end

  // Switch cells take SWITCH_ACK_LATENCY cycles to settle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `SWITCH_ACK_LATENCY; i++) begin
        ack_pipe_q[i] <= '0;
      end
    end else begin
      ack_pipe_q[0] <= switch_q;
      for (int i = 1; i < `SWITCH_ACK_LATENCY; i++) begin
        ack_pipe_q[i] <= ack_pipe_q[i-1];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= gnt;
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt) begin
      case (ofs)
        `PWR_SWITCH_OFS: rdata_q <= ext_pkg::data_t'(switch_q);
        `PWR_ACK_OFS:    rdata_q <= ext_pkg::data_t'(ack_pipe_q[`SWITCH_ACK_LATENCY-1]);
        default:         rdata_q <= '0;
      endcase
    end
  end

  assign pwr_switch_n_o = switch_q;
  assign pwr_ack_n_o    = ack_pipe_q[`SWITCH_ACK_LATENCY-1];

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_o.rvalid == $past(rsp_o.gnt));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the external subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module tb_ext_subsys -o sim_ext_subsys

./obj_dir/sim_ext_subsys > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST PASSED$" sim.log; then
  exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

// ==== slow_memory.sv ====
/* Word memory with byte-enable writes and a fixed
   grant-to-response latency */
`timescale 1ns/100ps
`default_nettype none

`include "ext_consts.svh"

module slow_memory (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  ext_pkg::bus_req_t req_i,
  output ext_pkg::bus_rsp_t rsp_o
);

  localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

  ext_pkg::data_t      mem_q [`MEM_NUM_WORDS];
  ext_pkg::mem_idx_t   idx;
  ext_pkg::mem_state_t state_q;
  logic [CNT_W-1:0]    cnt_q;
  ext_pkg::data_t      rdata_q;
  logic                gnt;

  assign idx = req_i.addr[`MEM_IDX_W+1:2];
  assign gnt = req_i.req && (state_q == ext_pkg::IDLE);

  always_comb begin
    rsp_o.gnt    = gnt;
    rsp_o.rvalid = (state_q == ext_pkg::BUSY) && (cnt_q == '0);
    rsp_o.rdata  = rdata_q;
  end

  // Countdown from grant to response
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ext_pkg::IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        ext_pkg::IDLE: begin
          if (gnt) begin
            state_q <= ext_pkg::BUSY;
            cnt_q   <= CNT_W'(`MEM_LATENCY - 1);
          end
        end
        ext_pkg::BUSY: begin
          if (cnt_q == '0) begin
            state_q <= ext_pkg::IDLE;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        default: state_q <= ext_pkg::IDLE;
      endcase
    end
  end

  // Array access happens on the grant edge, data waits in rdata_q
  always_ff @(posedge clk_i) begin
    if (gnt) begin
      if (req_i.we) begin
        for (int i = 0; i < `EXT_BE_W; i++) begin
          if (req_i.be[i]) begin
            mem_q[idx][8*i +: 8] <= req_i.wdata[8*i +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[idx];
      end
    end
  end

  // No second grant until the previous response is out
  for (genvar k = 1; k <= `MEM_LATENCY; k++) begin : g_busy_chk
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      rsp_o.gnt |-> !$past(rsp_o.gnt, k));
  end

endmodule

`default_nettype wire

// ==== tb_ext_subsys.sv ====
/* Testbench for the external bus subsystem: clock, reset, bus stimulus,
   memory and power reference model, response and protocol checks */
`timescale 1ns/100ps
`default_nettype none

`include "ext_consts.svh"

module tb_ext_subsys;

  localparam int TEST_WORDS     = 16;
  localparam int TIMEOUT_CYCLES = 4000;

  typedef struct packed {
    logic           is_read;
    ext_pkg::data_t data;
  } exp_t;

  logic                  clk;
  logic                  arst_n;
  ext_pkg::bus_req_t     bus_req;
  ext_pkg::bus_rsp_t     bus_rsp;
  ext_pkg::domain_mask_t pwr_switch_n;
  ext_pkg::domain_mask_t pwr_ack_n;
  logic                  req_unmapped;

  ext_pkg::data_t        mem_model [`MEM_NUM_WORDS];
  ext_pkg::domain_mask_t switch_model;
  exp_t                  exp_q [$];
  string                 test_name;
  int                    cycle_cnt;

  ext_subsys_top DUT (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .bus_req_i      (bus_req),
    .bus_rsp_o      (bus_rsp),
    .pwr_switch_n_o (pwr_switch_n),
    .pwr_ack_n_o    (pwr_ack_n)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Neither the memory region nor the power register window
  assign req_unmapped = (bus_req.addr >= (`MEM_BASE + `MEM_SIZE)) &&
                        !((bus_req.addr >= `PWR_BASE) &&
                          (bus_req.addr < (`PWR_BASE + `PWR_SIZE)));

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input ext_pkg::data_t exp,
                             input ext_pkg::data_t act);
    assert (act === exp) else begin
      report_failure($sformatf("CHECK FAILED: %s expected %h actual %h", name, exp, act));
    end
  endtask

  function automatic ext_pkg::data_t merge_bytes(input ext_pkg::data_t old_word,
                                                 input ext_pkg::data_t new_word,
                                                 input ext_pkg::be_t be);
    ext_pkg::data_t result;
    result = old_word;
    for (int b = 0; b < `EXT_BE_W; b++) begin
      if (be[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  // One request, held until granted; grant sampled mid-cycle
  task automatic issue(input logic we, input ext_pkg::be_t be, input ext_pkg::addr_t addr,
                       input ext_pkg::data_t wdata, input ext_pkg::data_t exp_rdata);
    exp_t e;
    logic granted;
    e.is_read     = !we;
    e.data        = exp_rdata;
    bus_req.req   = 1'b1;
    bus_req.we    = we;
    bus_req.be    = be;
    bus_req.addr  = addr;
    bus_req.wdata = wdata;
    granted       = 1'b0;
    while (!granted) begin
      @(negedge clk);
      granted = bus_rsp.gnt;
      @(posedge clk);
    end
    exp_q.push_back(e);
    #1;
    bus_req.req = 1'b0;
  endtask

  task automatic idle(input int n);
    bus_req.req = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic mem_write(input int idx, input ext_pkg::be_t be, input ext_pkg::data_t d);
    mem_model[idx] = merge_bytes(mem_model[idx], d, be);
    issue(1'b1, be, `MEM_BASE + ext_pkg::addr_t'(idx * 4), d, '0);
  endtask

  task automatic mem_read(input int idx);
    issue(1'b0, 4'hF, `MEM_BASE + ext_pkg::addr_t'(idx * 4), '0, mem_model[idx]);
  endtask

  task automatic pwr_access(input logic we, input logic [7:0] ofs, input ext_pkg::data_t d,
                            input ext_pkg::data_t exp_rdata);
    if (we && (ofs == `PWR_SWITCH_OFS)) begin
      switch_model = d[`EXT_DOMAINS-1:0];
    end
    issue(we, 4'hF, `PWR_BASE + ext_pkg::addr_t'(ofs), d, exp_rdata);
  endtask

  task automatic unmapped_access(input logic we, input ext_pkg::addr_t addr);
    issue(we, 4'hF, addr, ext_pkg::data_t'($urandom), `ERR_RDATA);
  endtask

  task automatic random_traffic(input int n);
    int sel;
    int idx;
    for (int k = 0; k < n; k++) begin
      sel = $urandom_range(9);
      idx = $urandom_range(TEST_WORDS - 1);
      if (sel < 6) begin
        if ($urandom_range(1) == 1) begin
          mem_write(idx, ext_pkg::be_t'($urandom), ext_pkg::data_t'($urandom));
        end else begin
          mem_read(idx);
        end
      end else if (sel < 9) begin
        case ($urandom_range(3))
          0: pwr_access(1'b1, `PWR_SWITCH_OFS, ext_pkg::data_t'($urandom_range(15)), '0);
          1: pwr_access(1'b0, `PWR_SWITCH_OFS, '0, ext_pkg::data_t'(switch_model));
          2: pwr_access(1'b1, 8'h08, ext_pkg::data_t'($urandom), '0);
          default: pwr_access(1'b0, 8'h08, '0, '0);
        endcase
      end else begin
        unmapped_access(($urandom_range(1) == 1),
                        `PWR_BASE + `PWR_SIZE + ext_pkg::addr_t'(idx * 4));
      end
      idle($urandom_range(3));
    end
  endtask

  // Every response is checked against the oldest accepted request
  always @(negedge clk) begin
    exp_t e;
    if (arst_n && bus_rsp.rvalid) begin
      if (exp_q.size() == 0) begin
        report_failure("A response arrived while no request was pending");
      end else begin
        e = exp_q.pop_front();
        if (e.is_read) begin
          check_value(test_name, e.data, bus_rsp.rdata);
        end
      end
    end
  end

  // About twice the length of all tests together
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      report_failure("Timeout: the run did not finish within the cycle limit");
    end
  end

  assert property (@(posedge clk) disable iff (!arst_n)
    (bus_req.req && !bus_rsp.gnt) |=> $stable(bus_req))
    else report_failure("The request changed before it was granted");

  assert property (@(posedge clk) disable iff (!arst_n)
    (bus_req.req && bus_rsp.gnt && req_unmapped) |=> bus_rsp.rvalid)
    else report_failure("An unmapped access was not answered one cycle after its grant");

  assert property (@(posedge clk) disable iff (!arst_n)
    !bus_req.req |-> !bus_rsp.gnt)
    else report_failure("A grant was given without a request");

  initial begin
    ext_pkg::domain_mask_t old_mask;
    ext_pkg::domain_mask_t new_mask;
    void'($urandom(32'h6844_8aca));
    arst_n       = 1'b0;
    bus_req      = '0;
    switch_model = '0;
    cycle_cnt    = 0;
    test_name    = "reset";
    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(posedge clk);
    #1;

    check_value(test_name, '0, ext_pkg::data_t'({bus_rsp.gnt, bus_rsp.rvalid}));
    check_value(test_name, '0, ext_pkg::data_t'(pwr_switch_n));
    check_value(test_name, '0, ext_pkg::data_t'(pwr_ack_n));

    // Full words first so later partial writes never merge into unknown bytes
    test_name = "mem_write_read";
    for (int i = 0; i < TEST_WORDS; i++) begin
      mem_write(i, 4'hF, ext_pkg::data_t'($urandom));
    end
    for (int i = 0; i < TEST_WORDS; i++) begin
      mem_write(i, ext_pkg::be_t'($urandom), ext_pkg::data_t'($urandom));
    end
    for (int i = 0; i < TEST_WORDS; i++) begin
      mem_read(i);
    end
    wait_drained();

    test_name = "pipelined_traffic";
    random_traffic(200);
    wait_drained();

    test_name = "unmapped";
    for (int i = 0; i < 4; i++) begin
      unmapped_access(1'b0, `PWR_BASE + `PWR_SIZE + ext_pkg::addr_t'(i * 4));
      unmapped_access(1'b1, `MEM_BASE + `MEM_SIZE + ext_pkg::addr_t'(i * 4));
      mem_read(i);
    end
    wait_drained();

    test_name = "power_switch";
    idle(`SWITCH_ACK_LATENCY + 5);
    check_value(test_name, ext_pkg::data_t'(switch_model), ext_pkg::data_t'(pwr_ack_n));
    old_mask = switch_model;
    new_mask = old_mask ^ ext_pkg::domain_mask_t'($urandom_range(15, 1));
    pwr_access(1'b1, `PWR_SWITCH_OFS, ext_pkg::data_t'(new_mask), '0);
    for (int j = 0; j <= `SWITCH_ACK_LATENCY; j++) begin
      check_value(test_name, ext_pkg::data_t'(new_mask), ext_pkg::data_t'(pwr_switch_n));
      if (j < `SWITCH_ACK_LATENCY) begin
        check_value(test_name, ext_pkg::data_t'(old_mask), ext_pkg::data_t'(pwr_ack_n));
        @(posedge clk);
        #1;
      end else begin
        check_value(test_name, ext_pkg::data_t'(new_mask), ext_pkg::data_t'(pwr_ack_n));
      end
    end
    pwr_access(1'b0, `PWR_ACK_OFS, '0, ext_pkg::data_t'(new_mask));
    wait_drained();
    idle(5);

    if (exp_q.size() == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      report_failure("Responses were still pending at the end of the run");
    end
  end

endmodule

`default_nettype wire
